//--- project.f
design/rv_isa_pkg.sv
design/rv_dpath_pkg.sv
design/rv_alu.sv
design/rv_regfile.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_mem_wb.sv
design/rv_dpath_top.sv
verif/rv_dpath_chk.sv
verif/tb_rv_dpath.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_dpath
FLAGS     ?= --timing --assert
BUILD     ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f project.f

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f project.f
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(BUILD)

//--- verif/tb_rv_dpath.sv
`timescale 1ns/1ps
// ------------------------------
// Table-driven datapath testbench with its own reference pipeline
// Table spaces dependent instructions by 4 slots, no forwarding
// ------------------------------
module tb_rv_dpath import rv_isa_pkg::*, rv_dpath_pkg::*;;

  typedef struct packed {
    inst_t     inst;
    dec_ctrl_t ctrl;
    pc_sel_t   pc_sel;
    word_t     resp;                 // Data response for the load in M
    logic      stall;
  } stim_t;

  typedef struct packed {
    word_t    imem;
    mem_req_t req;
    br_cond_t br;
    wb_t      wb;
    logic     chk_addr;              // Memory op present in X
    logic     chk_data;              // Store in X
    logic     chk_br;                // X holds a table entry
  } exp_t;

  logic      clk, reset, stall;
  inst_t     inst;
  dec_ctrl_t ctrl;
  pc_sel_t   pc_sel;
  word_t     dmem_resp_data;
  word_t     imem_addr;
  mem_req_t  dmem_req;
  br_cond_t  br_cond;
  wb_t       wb;

  stim_t  stim_q [$];
  exp_t   exp_q [$];
  integer seed = 32'h57fa;
  int     errors, checks, cycles;

  // Reference pipeline state
  word_t     regs_m [0:31];
  logic      x_valid;
  word_t     x_op0, x_op1, x_wdata, m_alu, w_data;
  dec_ctrl_t x_ctrl, m_ctrl;
  logic [4:0] x_rd, m_rd, w_rd;
  logic      w_en;
  word_t     m_pcf, m_pcd, m_tb, m_tj;

  rv_dpath_top u_dut (.*);

  always #4 clk = ~clk;              // 8 ns period

  // Run limit from the table length
  always @(posedge clk) begin
    if (!reset) begin
      cycles <= cycles + 1;
      if (cycles > stim_q.size() + 20) begin
        $display("Timeout: the table did not finish within %0d cycles", cycles);
        $display("TB FAILED");
        $finish;
      end
    end
  end

  task automatic check_value(input word_t got, input word_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // ------------------------------
  // Instruction encoders
  // ------------------------------
  function automatic inst_t enc_i(logic [11:0] imm, logic [4:0] rs1, logic [4:0] rd);
    return inst_t'({imm, rs1, 3'b000, rd, 7'h13});
  endfunction

  function automatic inst_t enc_r(logic [4:0] rs2, logic [4:0] rs1, logic [4:0] rd);
    return inst_t'({7'h00, rs2, rs1, 3'b000, rd, 7'h33});
  endfunction

  function automatic inst_t enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return inst_t'({imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23});
  endfunction

  function automatic inst_t enc_u(logic [19:0] imm, logic [4:0] rd);
    return inst_t'({imm, rd, 7'h37});
  endfunction

  function automatic inst_t enc_sb(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return inst_t'({imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'h63});
  endfunction

  function automatic inst_t enc_uj(logic [20:0] imm, logic [4:0] rd);
    return inst_t'({imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f});
  endfunction

  function automatic dec_ctrl_t mk_ctrl(op0_sel_t a, op1_sel_t b, alu_fn_t f, mem_op_t m,
                                        ld_fmt_t l, logic wm, logic we);
    dec_ctrl_t c;
    c.op0_sel = a;
    c.op1_sel = b;
    c.alu_fn  = f;
    c.mem_op  = m;
    c.ld_fmt  = l;
    c.wb_mem  = wm;
    c.rf_wen  = we;
    return c;
  endfunction

  // ------------------------------
  // Reference model, RV32I field rules
  // ------------------------------
  function automatic word_t operand1(logic [31:0] w, op1_sel_t sel, word_t rdat);
    case (sel)
      BM_RDAT:   return rdat;
      BM_SHAMT:  return {27'b0, w[24:20]};
      BM_IMM_U:  return {w[31:12], 12'b0};
      BM_IMM_SB: return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      BM_IMM_I:  return {{20{w[31]}}, w[31:20]};
      BM_IMM_S:  return {{20{w[31]}}, w[31:25], w[11:7]};
      default:   return '0;
    endcase
  endfunction

  function automatic word_t uj_imm(logic [31:0] w);
    return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
  endfunction

  function automatic word_t alu_ref(word_t a, word_t b, alu_fn_t fn);
    case (fn)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_SLL: return a << b[4:0];
      ALU_OR:  return a | b;
      ALU_LT:  return {31'b0, $signed(a) < $signed(b)};
      ALU_LTU: return {31'b0, a < b};
      ALU_AND: return a & b;
      ALU_XOR: return a ^ b;
      ALU_NOR: return ~(a | b);
      ALU_SRL: return a >> b[4:0];
      ALU_SRA: return word_t'($signed(a) >>> b[4:0]);
      default: return '0;
    endcase
  endfunction

  function automatic word_t load_extend(word_t d, ld_fmt_t fmt);
    case (fmt)
      LD_B:    return {{24{d[7]}}, d[7:0]};
      LD_BU:   return {24'b0, d[7:0]};
      LD_H:    return {{16{d[15]}}, d[15:0]};
      LD_HU:   return {16'b0, d[15:0]};
      default: return d;
    endcase
  endfunction

  // Expected outputs of one cycle, then advance unless stalled
  task automatic step_model(input stim_t s);
    exp_t        e;
    logic [31:0] w;
    word_t       rd0, rd1, op0, alu_x;
    w     = s.inst;
    alu_x = alu_ref(x_op0, x_op1, x_ctrl.alu_fn);
    case (s.pc_sel)
      PM_B:    e.imem = m_tb;
      PM_J:    e.imem = m_tj;
      default: e.imem = m_pcf + 32'd4;
    endcase
    e.req      = '{op: x_ctrl.mem_op, addr: alu_x, data: x_wdata};
    e.br       = '{eq: x_op0 == x_op1, ne: x_op0 != x_op1,
                   lt: $signed(x_op0) < $signed(x_op1), ltu: x_op0 < x_op1,
                   ge: $signed(x_op0) >= $signed(x_op1), geu: x_op0 >= x_op1};
    e.wb       = '{en: w_en, rd: w_rd, data: w_data};
    e.chk_addr = (x_ctrl.mem_op != MEM_NONE);
    e.chk_data = (x_ctrl.mem_op == MEM_ST);
    e.chk_br   = x_valid;
    exp_q.push_back(e);
    if (!s.stall) begin
      rd0 = regs_m[w[19:15]];        // Read before this cycle's write
      rd1 = regs_m[w[24:20]];
      case (s.ctrl.op0_sel)
        AM_RDAT: op0 = rd0;
        AM_PC:   op0 = m_pcd;
        AM_PC4:  op0 = m_pcd + 32'd4;
        default: op0 = '0;
      endcase
      if (w_en && w_rd != '0) regs_m[w_rd] = w_data;
      w_en    = m_ctrl.rf_wen;
      w_rd    = m_rd;
      w_data  = m_ctrl.wb_mem ? load_extend(s.resp, m_ctrl.ld_fmt) : m_alu;
      m_alu   = alu_x;
      m_ctrl  = x_ctrl;
      m_rd    = x_rd;
      x_op0   = op0;
      x_op1   = operand1(w, s.ctrl.op1_sel, rd1);
      x_wdata = rd1;
      x_ctrl  = s.ctrl;
      x_rd    = w[11:7];
      x_valid = 1'b1;
      m_tb    = m_pcd + operand1(w, BM_IMM_SB, '0);
      m_tj    = m_pcd + uj_imm(w);
      m_pcd   = m_pcf;
      m_pcf   = e.imem;
    end
  endtask

  task automatic add_entry(input inst_t i, input dec_ctrl_t c, input pc_sel_t ps,
                           input logic st);
    stim_t s;
    word_t r;
    r = $random(seed) | 32'h8000_8080;  // Sign bits of every load size set
    s.inst   = i;
    s.ctrl   = c;
    s.pc_sel = ps;
    s.resp   = r;
    s.stall  = st;
    stim_q.push_back(s);
  endtask

  task automatic add_nop(input pc_sel_t ps, input logic st);
    add_entry('0, '0, ps, st);
  endtask

  // ------------------------------
  // Table contents
  // ------------------------------
  task automatic build_table();
    word_t r;
    alu_fn_t fn;
    add_entry(enc_i(12'h0a5, 5'd0, 5'd1), mk_ctrl(AM_0, BM_IMM_I, ALU_ADD, MEM_NONE, LD_W, 0, 1),
              PM_P, 0);
    for (int k = 2; k <= 7; k++) begin
      r = $random(seed);
      case (k)
        2: add_entry(enc_i(r[11:0], 5'd0, 5'd2),
                     mk_ctrl(AM_0, BM_IMM_I, ALU_ADD, MEM_NONE, LD_W, 0, 1), PM_P, 0);
        3: add_entry(enc_u(r[19:0], 5'd3),
                     mk_ctrl(AM_0, BM_IMM_U, ALU_ADD, MEM_NONE, LD_W, 0, 1), PM_P, 0);
        4: add_entry(enc_i(12'h7ff, 5'd0, 5'd4),
                     mk_ctrl(AM_0, BM_IMM_I, ALU_ADD, MEM_NONE, LD_W, 0, 1), PM_P, 0);
        5: add_entry(enc_i(12'hfff, 5'd0, 5'd5),
                     mk_ctrl(AM_0, BM_IMM_I, ALU_ADD, MEM_NONE, LD_W, 0, 1), PM_P, 0);
        6: add_entry(enc_i(12'h005, 5'd0, 5'd6),
                     mk_ctrl(AM_0, BM_IMM_I, ALU_ADD, MEM_NONE, LD_W, 0, 1), PM_P, 0);
        default: add_entry(enc_i(12'h100, 5'd0, 5'd7),
                           mk_ctrl(AM_0, BM_IMM_I, ALU_ADD, MEM_NONE, LD_W, 0, 1), PM_P, 0);
      endcase
    end
    repeat (3) add_nop(PM_P, 0);    // x7 settles before first read
    for (int f = 0; f <= 10; f++) begin
      fn = alu_fn_t'(f);
      add_entry(enc_r(5'd2, 5'd1, 5'(8 + f)),
                mk_ctrl(AM_RDAT, BM_RDAT, fn, MEM_NONE, LD_W, 0, 1), PM_P, 0);
    end
    for (int f = 0; f <= 10; f++) begin
      fn = alu_fn_t'(f);
      r  = $random(seed);
      add_entry(enc_i(r[11:0], 5'd3, 5'(20 + f)),
                mk_ctrl(AM_RDAT, (fn == ALU_SLL || fn == ALU_SRL || fn == ALU_SRA) ?
                        BM_SHAMT : BM_IMM_I, fn, MEM_NONE, LD_W, 0, 1), PM_P, 0);
    end
    for (int f = 0; f <= 4; f++) begin
      r = $random(seed);
      add_entry(enc_i({4'b0, r[7:0]}, 5'd7, 5'(8 + f)),
                mk_ctrl(AM_RDAT, BM_IMM_I, ALU_ADD, MEM_LD, ld_fmt_t'(f), 1, 1), PM_P, 0);
    end
    add_entry(enc_s(12'h01c, 5'd5, 5'd7),
              mk_ctrl(AM_RDAT, BM_IMM_S, ALU_ADD, MEM_ST, LD_W, 0, 0), PM_P, 0);
    add_entry(enc_s(12'hff0, 5'd2, 5'd7),
              mk_ctrl(AM_RDAT, BM_IMM_S, ALU_ADD, MEM_ST, LD_W, 0, 0), PM_P, 0);
    // Branches, redirect taken the cycle after decode
    r = $random(seed);
    add_entry(enc_sb({r[12:1], 1'b0}, 5'd2, 5'd1),
              mk_ctrl(AM_RDAT, BM_RDAT, ALU_SUB, MEM_NONE, LD_W, 0, 0), PM_P, 0);
    add_nop(PM_B, 0);
    add_entry(enc_sb(13'h0040, 5'd4, 5'd5),
              mk_ctrl(AM_RDAT, BM_RDAT, ALU_SUB, MEM_NONE, LD_W, 0, 0), PM_P, 0);
    add_entry(enc_sb(13'h1ff8, 5'd1, 5'd3),
              mk_ctrl(AM_RDAT, BM_RDAT, ALU_SUB, MEM_NONE, LD_W, 0, 0), PM_B, 0);
    r = $random(seed);
    add_entry(enc_uj({r[20:1], 1'b0}, 5'd31),
              mk_ctrl(AM_PC4, BM_0, ALU_ADD, MEM_NONE, LD_W, 0, 1), PM_P, 0);
    add_nop(PM_J, 0);
    // Stall while x13 sits in W
    add_entry(enc_i(12'h123, 5'd6, 5'd13),
              mk_ctrl(AM_RDAT, BM_IMM_I, ALU_ADD, MEM_NONE, LD_W, 0, 1), PM_P, 0);
    repeat (2) add_nop(PM_P, 0);
    repeat (3) add_nop(PM_P, 1);
    // First D slot after the stall still reads the old x13
    add_entry(enc_r(5'd0, 5'd13, 5'd15),
              mk_ctrl(AM_RDAT, BM_0, ALU_ADD, MEM_NONE, LD_W, 0, 1), PM_P, 0);
    add_nop(PM_P, 0);
    add_entry(enc_r(5'd0, 5'd13, 5'd14),
              mk_ctrl(AM_RDAT, BM_0, ALU_ADD, MEM_NONE, LD_W, 0, 1), PM_P, 0);
    repeat (4) add_nop(PM_P, 0);    // Drain
  endtask

  task automatic compare_outputs(input exp_t e);
    check_value(imem_addr, e.imem, "imem_addr");
    check_value(word_t'(wb.en), word_t'(e.wb.en), "wb.en");
    if (e.wb.en) begin
      check_value(word_t'(wb.rd), word_t'(e.wb.rd), "wb.rd");
      check_value(wb.data, e.wb.data, "wb.data");
    end
    check_value(word_t'(dmem_req.op), word_t'(e.req.op), "dmem_req.op");
    if (e.chk_addr) check_value(dmem_req.addr, e.req.addr, "dmem_req.addr");
    if (e.chk_data) check_value(dmem_req.data, e.req.data, "dmem_req.data");
    if (e.chk_br) check_value(word_t'(br_cond), word_t'(e.br), "br_cond");
  endtask

  initial begin
    clk            = 1'b0;
    reset          = 1'b1;
    stall          = 1'b0;
    inst           = '0;
    ctrl           = '0;
    pc_sel         = PM_P;
    dmem_resp_data = '0;
    errors         = 0;
    checks         = 0;
    cycles         = 0;
    for (int k = 0; k < 32; k++) regs_m[k] = '0;
    x_valid = 1'b0;
    x_ctrl  = '0;
    m_ctrl  = '0;
    w_en    = 1'b0;
    m_pcf   = RESET_VECTOR;           // Reset leaves both PCs here
    m_pcd   = RESET_VECTOR;
    build_table();
    for (int k = 0; k < stim_q.size(); k++) step_model(stim_q[k]);
    repeat (7) @(posedge clk);
    for (int k = 0; k < stim_q.size(); k++) begin
      @(posedge clk);
      if (k == 0) reset <= 1'b0;      // 8th edge releases reset
      inst           <= stim_q[k].inst;
      ctrl           <= stim_q[k].ctrl;
      pc_sel         <= stim_q[k].pc_sel;
      dmem_resp_data <= stim_q[k].resp;
      stall          <= stim_q[k].stall;
      @(negedge clk);
      compare_outputs(exp_q[k]);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- verif/rv_dpath_chk.sv
`timescale 1ns/1ps
// ------------------------------
// Port-level assertions, bound to the datapath top
// ------------------------------
module rv_dpath_chk
  import rv_isa_pkg::*, rv_dpath_pkg::*;
(
  input logic     clk,
  input logic     reset,
  input logic     stall,
  input pc_sel_t  pc_sel,
  input word_t    imem_addr,
  input mem_req_t dmem_req,
  input br_cond_t br_cond,
  input wb_t      wb
);

  a_reset_pc: assert property (@(posedge clk) reset |-> imem_addr == RESET_VECTOR)
    else $error("imem_addr differs from the reset vector during reset");

  a_wb_idle: assert property (@(posedge clk) ($past(reset) && !reset) |-> !wb.en)
    else $error("wb.en high right after reset");

  // Flag pairs are exact opposites
  a_flags: assert property (@(posedge clk) disable iff (reset)
      !$isunknown(br_cond) |-> (br_cond.eq ^ br_cond.ne) && (br_cond.lt ^ br_cond.ge)
                               && (br_cond.ltu ^ br_cond.geu))
    else $error("branch flags not complementary");

  a_hold: assert property (@(posedge clk) disable iff (reset)
      ($past(stall) && !$past(reset)) |-> $stable(wb) && $stable(dmem_req))
    else $error("wb or dmem_req changed across a stall");

  a_pc_hold: assert property (@(posedge clk) disable iff (reset)
      ($past(stall) && !$past(reset) && $stable(pc_sel)) |-> $stable(imem_addr))
    else $error("imem_addr changed across a stall");

endmodule

bind rv_dpath_top rv_dpath_chk u_chk (
  .clk       (clk),
  .reset     (reset),
  .stall     (stall),
  .pc_sel    (pc_sel),
  .imem_addr (imem_addr),
  .dmem_req  (dmem_req),
  .br_cond   (br_cond),
  .wb        (wb)
);

//--- design/rv_dpath_top.sv
`timescale 1ns/1ps
// ------------------------------
// Five-stage datapath top, one global stall
// Control comes in at D, no forwarding
// ------------------------------
module rv_dpath_top
  import rv_isa_pkg::*, rv_dpath_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      stall,
  input  inst_t     inst,
  input  dec_ctrl_t ctrl,
  input  pc_sel_t   pc_sel,
  input  word_t     dmem_resp_data,
  output word_t     imem_addr,
  output mem_req_t  dmem_req,
  output br_cond_t  br_cond,
  output wb_t       wb
);

  word_t     pc_f, pc_plus4_f;
  redirect_t redirect;
  word_t     op0_x, op1_x, wdata_x;
  ex_ctrl_t  ex_ctrl_x;
  word_t     alu_m;
  mw_ctrl_t  mw_ctrl_m;

  rv_fetch u_fetch (
    .clk        (clk),
    .reset      (reset),
    .stall      (stall),
    .pc_sel     (pc_sel),
    .redirect   (redirect),
    .imem_addr  (imem_addr),
    .pc_f       (pc_f),
    .pc_plus4_f (pc_plus4_f)
  );

  rv_decode u_decode (
    .clk        (clk),
    .reset      (reset),
    .stall      (stall),
    .inst       (inst),
    .ctrl       (ctrl),
    .pc_f       (pc_f),
    .pc_plus4_f (pc_plus4_f),
    .wr         (wb),              // W stage closes the loop
    .op0_x      (op0_x),
    .op1_x      (op1_x),
    .wdata_x    (wdata_x),
    .ex_ctrl_x  (ex_ctrl_x),
    .redirect   (redirect)
  );

  rv_execute u_execute (
    .clk       (clk),
    .reset     (reset),
    .stall     (stall),
    .op0_x     (op0_x),
    .op1_x     (op1_x),
    .wdata_x   (wdata_x),
    .ex_ctrl_x (ex_ctrl_x),
    .br_cond   (br_cond),
    .dmem_req  (dmem_req),
    .alu_m     (alu_m),
    .mw_ctrl_m (mw_ctrl_m)
  );

  rv_mem_wb u_mem_wb (
    .clk            (clk),
    .reset          (reset),
    .stall          (stall),
    .alu_m          (alu_m),
    .mw_ctrl_m      (mw_ctrl_m),
    .dmem_resp_data (dmem_resp_data),
    .wb             (wb)
  );

endmodule

//--- design/rv_mem_wb.sv
`timescale 1ns/1ps
// ------------------------------
// Load adjust, writeback mux and W register
// Loads assume the response is already aligned
// ------------------------------
module rv_mem_wb
  import rv_isa_pkg::*, rv_dpath_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     stall,
  input  word_t    alu_m,
  input  mw_ctrl_t mw_ctrl_m,
  input  word_t    dmem_resp_data,  // Sampled in M
  output wb_t      wb
);

  word_t             ld_data_m, wb_data_m;
  logic              wb_en_w;
  logic [REG_AW-1:0] wb_rd_w;
  word_t             wb_data_w;

  // Subword extend
  always_comb begin
    case (mw_ctrl_m.ld_fmt)
      LD_B:    ld_data_m = {{(XLEN-8){dmem_resp_data[7]}}, dmem_resp_data[7:0]};
      LD_BU:   ld_data_m = {{(XLEN-8){1'b0}}, dmem_resp_data[7:0]};
      LD_H:    ld_data_m = {{(XLEN-16){dmem_resp_data[15]}}, dmem_resp_data[15:0]};
      LD_HU:   ld_data_m = {{(XLEN-16){1'b0}}, dmem_resp_data[15:0]};
      default: ld_data_m = dmem_resp_data;   // LD_W
    endcase
  end

  assign wb_data_m = mw_ctrl_m.wb_mem ? ld_data_m : alu_m;

  // ------------------------------
  // W <- M
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_en_w <= 1'b0;
    end else if (!stall) begin
      wb_en_w <= mw_ctrl_m.rf_wen;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      wb_rd_w   <= mw_ctrl_m.rd;
      wb_data_w <= wb_data_m;
    end
  end

  assign wb = '{en: wb_en_w, rd: wb_rd_w, data: wb_data_w};  // Also the RF write port

endmodule

//--- design/rv_execute.sv
`timescale 1ns/1ps
// ------------------------------
// Execute, branch flags and dmem request
// Request is presented in X, response expected in M
// ------------------------------
module rv_execute
  import rv_isa_pkg::*, rv_dpath_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     stall,
  input  word_t    op0_x,
  input  word_t    op1_x,
  input  word_t    wdata_x,
  input  ex_ctrl_t ex_ctrl_x,
  output br_cond_t br_cond,
  output mem_req_t dmem_req,
  output word_t    alu_m,
  output mw_ctrl_t mw_ctrl_m
);

  word_t alu_x;

  rv_alu u_alu (
    .a  (op0_x),
    .b  (op1_x),
    .fn (ex_ctrl_x.alu_fn),
    .y  (alu_x)
  );

  // Branch flags on the raw operands
  assign br_cond.eq  = (op0_x == op1_x);
  assign br_cond.ne  = (op0_x != op1_x);
  assign br_cond.lt  = ($signed(op0_x) < $signed(op1_x));
  assign br_cond.ltu = (op0_x < op1_x);
  assign br_cond.ge  = ($signed(op0_x) >= $signed(op1_x));
  assign br_cond.geu = (op0_x >= op1_x);

  // Effective address from ALU
  assign dmem_req = '{op: ex_ctrl_x.mem_op, addr: alu_x, data: wdata_x};

  // ------------------------------
  // M <- X
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!stall) alu_m <= alu_x;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mw_ctrl_m <= '0;
    end else if (!stall) begin
      mw_ctrl_m <= '{ld_fmt: ex_ctrl_x.ld_fmt, wb_mem: ex_ctrl_x.wb_mem,
                     rf_wen: ex_ctrl_x.rf_wen, rd: ex_ctrl_x.rd};
    end
  end

endmodule

//--- design/rv_decode.sv
`timescale 1ns/1ps
// ------------------------------
// Decode, register read and D->X register
// No bypassing, producers must be 4 slots ahead
// ------------------------------
module rv_decode
  import rv_isa_pkg::*, rv_dpath_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      stall,
  input  inst_t     inst,          // Instruction in D
  input  dec_ctrl_t ctrl,          // Its control bundle
  input  word_t     pc_f,
  input  word_t     pc_plus4_f,
  input  wb_t       wr,            // From W
  output word_t     op0_x,
  output word_t     op1_x,
  output word_t     wdata_x,       // Store data
  output ex_ctrl_t  ex_ctrl_x,
  output redirect_t redirect
);

  word_t pc_d, pc_plus4_d;
  word_t rdata0, rdata1;
  logic [IMM_I_W-1:0]  imm_i_raw;
  logic [IMM_S_W-1:0]  imm_s_raw;
  logic [IMM_SB_W-1:0] imm_sb_raw;
  logic [IMM_U_W-1:0]  imm_u_raw;
  logic [IMM_UJ_W-1:0] imm_uj_raw;
  word_t imm_i, imm_s, imm_sb, imm_u, imm_uj, shamt;
  word_t op0_d, op1_d;

  // D <- F, PC copies only
  always_ff @(posedge clk) begin
    if (!stall) begin
      pc_d       <= pc_f;
      pc_plus4_d <= pc_plus4_f;
    end
  end

  rv_regfile u_regfile (
    .clk    (clk),
    .raddr0 (inst.r.rs1),
    .raddr1 (inst.r.rs2),
    .rdata0 (rdata0),
    .rdata1 (rdata1),
    .wr     (wr),
    .stall  (stall)
  );

  // ------------------------------
  // Immediates
  // ------------------------------
  assign imm_i_raw  = {inst.r.funct7, inst.r.rs2};
  assign imm_s_raw  = {inst.s.imm_hi, inst.s.imm_lo};
  assign imm_sb_raw = {inst.s.imm_hi[6], inst.s.imm_lo[0], inst.s.imm_hi[5:0],
                       inst.s.imm_lo[4:1], 1'b0};
  assign imm_u_raw  = {inst.r.funct7, inst.r.rs2, inst.r.rs1, inst.r.funct3};
  // inst[31], inst[19:12], inst[20], inst[30:21]
  assign imm_uj_raw = {inst.r.funct7[6], inst.r.rs1, inst.r.funct3, inst.r.rs2[0],
                       inst.r.funct7[5:0], inst.r.rs2[4:1], 1'b0};

  assign imm_i  = {{(XLEN-IMM_I_W){imm_i_raw[IMM_I_W-1]}}, imm_i_raw};
  assign imm_s  = {{(XLEN-IMM_S_W){imm_s_raw[IMM_S_W-1]}}, imm_s_raw};
  assign imm_sb = {{(XLEN-IMM_SB_W){imm_sb_raw[IMM_SB_W-1]}}, imm_sb_raw};
  assign imm_u  = {imm_u_raw, {(XLEN-IMM_U_W){1'b0}}};   // Upper 20 bits
  assign imm_uj = {{(XLEN-IMM_UJ_W){imm_uj_raw[IMM_UJ_W-1]}}, imm_uj_raw};
  assign shamt  = {{(XLEN-SHAMT_W){1'b0}}, inst.r.rs2};  // Zero-extended

  // Operand muxes
  always_comb begin
    case (ctrl.op0_sel)
      AM_RDAT: op0_d = rdata0;
      AM_PC:   op0_d = pc_d;
      AM_PC4:  op0_d = pc_plus4_d;
      default: op0_d = '0;         // AM_0
    endcase
    case (ctrl.op1_sel)
      BM_RDAT:   op1_d = rdata1;
      BM_SHAMT:  op1_d = shamt;
      BM_IMM_U:  op1_d = imm_u;
      BM_IMM_SB: op1_d = imm_sb;
      BM_IMM_I:  op1_d = imm_i;
      BM_IMM_S:  op1_d = imm_s;
      default:   op1_d = '0;       // BM_0 and unused code
    endcase
  end

  // ------------------------------
  // X <- D
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!stall) begin
      op0_x                <= op0_d;
      op1_x                <= op1_d;
      wdata_x              <= rdata1;
      redirect.branch_targ <= pc_d + imm_sb;
      redirect.jump_targ   <= pc_d + imm_uj;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_ctrl_x <= '0;             // No write, no memory op
    end else if (!stall) begin
      ex_ctrl_x <= '{alu_fn: ctrl.alu_fn, mem_op: ctrl.mem_op, ld_fmt: ctrl.ld_fmt,
                     wb_mem: ctrl.wb_mem, rf_wen: ctrl.rf_wen, rd: inst.r.rd};
    end
  end

endmodule

//--- design/rv_fetch.sv
`timescale 1ns/1ps
// ------------------------------
// Next-PC select and fetch PC
// imem_addr is combinational, no jump-register path
// ------------------------------
module rv_fetch
  import rv_isa_pkg::*, rv_dpath_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      stall,         // Freezes the PC
  input  pc_sel_t   pc_sel,
  input  redirect_t redirect,      // Targets held in X
  output word_t     imem_addr,
  output word_t     pc_f,
  output word_t     pc_plus4_f
);

  word_t pc_next;

  assign pc_plus4_f = pc_f + word_t'(4);  // Incrementer

  // Next-PC mux
  always_comb begin
    case (pc_sel)
      PM_B:    pc_next = redirect.branch_targ;
      PM_J:    pc_next = redirect.jump_targ;
      default: pc_next = pc_plus4_f;        // PM_P and unused code
    endcase
  end

  // Request goes out in the same cycle
  assign imem_addr = reset ? RESET_VECTOR : pc_next;

  // ------------------------------
  // F <- P
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      pc_f <= RESET_VECTOR;
    end else if (!stall) begin
      pc_f <= pc_next;
    end
  end

endmodule

//--- design/rv_regfile.sv
`timescale 1ns/1ps
// ------------------------------
// 2R1W register file, x0 reads zero
// Reads see the old value during a same-cycle write
// ------------------------------
module rv_regfile
  import rv_isa_pkg::*, rv_dpath_pkg::*;
(
  input  logic              clk,
  input  logic [REG_AW-1:0] raddr0,
  input  logic [REG_AW-1:0] raddr1,
  output word_t             rdata0,
  output word_t             rdata1,
  input  wb_t               wr,      // Writeback port
  input  logic              stall
);

  word_t regs [1:31];              // No storage for x0

  // Combinational read, x0 forced to zero
  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

  // Write at the edge, never while stalled
  always_ff @(posedge clk) begin
    if (wr.en && !stall && (wr.rd != '0)) begin
      regs[wr.rd] <= wr.data;
    end
  end

endmodule

//--- design/rv_alu.sv
`timescale 1ns/1ps
// ------------------------------
// Combinational ALU
// Shift amount is b[4:0]
// ------------------------------
module rv_alu
  import rv_isa_pkg::*, rv_dpath_pkg::*;
(
  input  word_t   a,
  input  word_t   b,
  input  alu_fn_t fn,
  output word_t   y
);

  logic [SHAMT_W-1:0] sh;
  logic               lt_s, lt_u;

  assign sh   = b[SHAMT_W-1:0];
  assign lt_s = $signed(a) < $signed(b);
  assign lt_u = a < b;

  always_comb begin
    case (fn)
      ALU_ADD: y = a + b;
      ALU_SUB: y = a - b;
      ALU_SLL: y = a << sh;
      ALU_OR:  y = a | b;
      ALU_LT:  y = {{(XLEN-1){1'b0}}, lt_s};   // Set-less-than
      ALU_LTU: y = {{(XLEN-1){1'b0}}, lt_u};
      ALU_AND: y = a & b;
      ALU_XOR: y = a ^ b;
      ALU_NOR: y = ~(a | b);
      ALU_SRL: y = a >> sh;
      ALU_SRA: y = word_t'($signed(a) >>> sh); // Arithmetic
      default: y = '0;
    endcase
  end

endmodule

//--- design/rv_dpath_pkg.sv
// ------------------------------
// Datapath control encodings and stage bundles
// Encodings follow the existing control unit
// ------------------------------
package rv_dpath_pkg;

  import rv_isa_pkg::*;

  typedef enum logic [1:0] {
    PM_P = 2'd0,                   // PC + 4
    PM_B = 2'd1,                   // Branch target
    PM_J = 2'd2                    // Jump target
  } pc_sel_t;

  typedef enum logic [1:0] {
    AM_RDAT = 2'd0, AM_PC = 2'd1, AM_PC4 = 2'd2, AM_0 = 2'd3
  } op0_sel_t;

  typedef enum logic [2:0] {
    BM_RDAT = 3'd0, BM_SHAMT = 3'd1, BM_IMM_U = 3'd2, BM_IMM_SB = 3'd3,
    BM_IMM_I = 3'd4, BM_IMM_S = 3'd5, BM_0 = 3'd6
  } op1_sel_t;

  typedef enum logic [3:0] {
    ALU_ADD = 4'd0, ALU_SUB = 4'd1, ALU_SLL = 4'd2, ALU_OR  = 4'd3,
    ALU_LT  = 4'd4, ALU_LTU = 4'd5, ALU_AND = 4'd6, ALU_XOR = 4'd7,
    ALU_NOR = 4'd8, ALU_SRL = 4'd9, ALU_SRA = 4'd10
  } alu_fn_t;

  typedef enum logic [1:0] {MEM_NONE = 2'd0, MEM_LD = 2'd1, MEM_ST = 2'd2} mem_op_t;

  typedef enum logic [2:0] {
    LD_W = 3'd0, LD_B = 3'd1, LD_BU = 3'd2, LD_H = 3'd3, LD_HU = 3'd4
  } ld_fmt_t;

  // ------------------------------
  // Per-instruction control, enters at D
  // ------------------------------
  typedef struct packed {
    op0_sel_t op0_sel;
    op1_sel_t op1_sel;
    alu_fn_t  alu_fn;
    mem_op_t  mem_op;
    ld_fmt_t  ld_fmt;
    logic     wb_mem;              // 1 selects load data at writeback
    logic     rf_wen;
  } dec_ctrl_t;

  typedef struct packed {
    alu_fn_t           alu_fn;
    mem_op_t           mem_op;
    ld_fmt_t           ld_fmt;
    logic              wb_mem;
    logic              rf_wen;
    logic [REG_AW-1:0] rd;
  } ex_ctrl_t;

  typedef struct packed {
    ld_fmt_t           ld_fmt;
    logic              wb_mem;
    logic              rf_wen;
    logic [REG_AW-1:0] rd;
  } mw_ctrl_t;

  typedef struct packed {
    mem_op_t op;
    word_t   addr;
    word_t   data;
  } mem_req_t;

  typedef struct packed {
    logic eq, ne, lt, ltu, ge, geu;
  } br_cond_t;

  typedef struct packed {
    logic              en;
    logic [REG_AW-1:0] rd;
    word_t             data;
  } wb_t;

  typedef struct packed {
    word_t branch_targ;
    word_t jump_targ;
  } redirect_t;

endpackage

//--- design/rv_isa_pkg.sv
// ------------------------------
// RV32I widths, reset vector and instruction views
// Only the fields the datapath decodes are named
// ------------------------------
package rv_isa_pkg;

  localparam int XLEN    = 32;     // Data and address width
  localparam int REG_AW  = 5;      // Register specifier width

  // Raw immediate widths before extension
  localparam int IMM_I_W  = 12;
  localparam int IMM_S_W  = 12;
  localparam int IMM_SB_W = 13;    // Includes the implied zero LSB
  localparam int IMM_U_W  = 20;
  localparam int IMM_UJ_W = 21;    // Includes the implied zero LSB
  localparam int SHAMT_W  = 5;

  typedef logic [XLEN-1:0] word_t;

  localparam word_t RESET_VECTOR = 32'h0008_0000;  // First fetch

  // R and I formats share one layout
  typedef struct packed {
    logic [6:0]        funct7;     // Also I immediate high part
    logic [REG_AW-1:0] rs2;        // Also shamt and I immediate low part
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [REG_AW-1:0] rd;
    logic [6:0]        opcode;
  } inst_r_t;

  // S and SB formats split the immediate around rs2/rs1
  typedef struct packed {
    logic [6:0]        imm_hi;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [4:0]        imm_lo;
    logic [6:0]        opcode;
  } inst_s_t;

  typedef union packed {
    inst_r_t r;
    inst_s_t s;
  } inst_t;

endpackage
